// ==== lcd_cfg.svh ====
/* LCD debug display configuration */

`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// Visible area of the 800 by 480 panel.
`define LCD_H_ACTIVE 800
`define LCD_V_ACTIVE 480

// Horizontal blanking, in pixel ticks.
`define LCD_H_FRONT 40
`define LCD_H_SYNC 128
`define LCD_H_BACK 88
`define LCD_H_TOTAL (`LCD_H_ACTIVE + `LCD_H_FRONT + `LCD_H_SYNC + `LCD_H_BACK)

// Vertical blanking, in lines.
`define LCD_V_FRONT 1
`define LCD_V_SYNC 3
`define LCD_V_BACK 23
`define LCD_V_TOTAL (`LCD_V_ACTIVE + `LCD_V_FRONT + `LCD_V_SYNC + `LCD_V_BACK)

// Scan counter widths.
`define LCD_X_BITS 11
`define LCD_Y_BITS 10

// Text layer. Glyph pixels are 4 by 4 screen pixels.
`define TEXT_LOG2_SCALE 2
`define GLYPH_W 8
`define GLYPH_H 16
`define TEXT_DIGITS 8
`define TEXT_WORDS 3
`define OVERLAY_RED 8'h80

// Backlight, 50 MHz / 250 / 1000 gives 200 Hz.
`define PWM_MAX 1000
`define PWM_BITS 10
`define PWM_PRESCALE 250

// Host register map and reset contents.
`define REG_DEBUG0 32'h0000_0000
`define REG_DEBUG1 32'h0000_0004
`define REG_DEBUG2 32'h0000_0008
`define REG_CTRL 32'h0000_000c
`define DEBUG0_RESET 32'hdead_beef
`define DEBUG1_RESET 32'hcafe_babe
`define DEBUG2_RESET 32'hface_feed
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== lcd_pkg.sv ====
/* LCD debug display types */

`include "lcd_cfg.svh"

package lcd_pkg;

    // Host control word.
    // Read raw by the bus, by fields in the display blocks.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // Stored but unused.
            logic [31-`PWM_BITS-2:0] reserved;
            // Backlight level, 0 to PWM_MAX.
            logic [`PWM_BITS-1:0] brightness;
            // Zero means full brightness.
            logic brightness_sel;
            // Shows the hex text layer.
            logic overlay_en;
        } ctrl;
    } host_word_u;

endpackage

// ==== lcd_scan_if.sv ====
/* LCD scan bundle */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

interface lcd_scan_if;

    // Pixel tick, high every second clock.
    logic tick;
    // Scan position and panel sync.
    logic [`LCD_X_BITS-1:0] x;
    logic [`LCD_Y_BITS-1:0] y;
    logic de;
    logic hs_n;
    logic vs_n;

    modport source (output tick, x, y, de, hs_n, vs_n);
    modport sink (input tick, x, y, de, hs_n, vs_n);

endinterface

// ==== lcd_timing.sv ====
/* LCD scan timing generator */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module lcd_timing (
    input logic clock_50,
    input logic rst,
    lcd_scan_if.source scan
);

    // Last counter values of a line and a frame.
    localparam logic [`LCD_X_BITS-1:0] X_LAST = `LCD_H_TOTAL - 1;
    localparam logic [`LCD_Y_BITS-1:0] Y_LAST = `LCD_V_TOTAL - 1;

    // Sync windows, start inclusive and end exclusive.
    localparam logic [`LCD_X_BITS-1:0] HS_START = `LCD_H_ACTIVE + `LCD_H_FRONT;
    localparam logic [`LCD_X_BITS-1:0] HS_END = `LCD_H_ACTIVE + `LCD_H_FRONT + `LCD_H_SYNC;
    localparam logic [`LCD_Y_BITS-1:0] VS_START = `LCD_V_ACTIVE + `LCD_V_FRONT;
    localparam logic [`LCD_Y_BITS-1:0] VS_END = `LCD_V_ACTIVE + `LCD_V_FRONT + `LCD_V_SYNC;

    logic [`LCD_X_BITS-1:0] x_next;
    logic [`LCD_Y_BITS-1:0] y_next;

    // Next scan position.
    always_comb begin
        x_next = scan.x + 1'b1;
        y_next = scan.y;
        if (scan.x == X_LAST) begin
            x_next = '0;
            // Line wrap steps the row.
            y_next = (scan.y == Y_LAST) ? '0 : scan.y + 1'b1;
        end
    end

    // Counters and sync all move on the same tick.
    always_ff @(posedge clock_50) begin
        if (rst) begin
            scan.tick <= 1'b0;
            // Parked on the last blank pixel.
            // The first tick lands on pixel 0, 0.
            scan.x <= X_LAST;
            scan.y <= Y_LAST;
            scan.de <= 1'b0;
            scan.hs_n <= 1'b1;
            scan.vs_n <= 1'b1;
        end else begin
            // Half rate pixel clock.
            scan.tick <= ~scan.tick;
            if (scan.tick) begin
                scan.x <= x_next;
                scan.y <= y_next;
                // Flags follow the new position.
                scan.de <= (x_next < `LCD_H_ACTIVE) && (y_next < `LCD_V_ACTIVE);
                scan.hs_n <= !((x_next >= HS_START) && (x_next < HS_END));
                scan.vs_n <= !((y_next >= VS_START) && (y_next < VS_END));
            end
        end
    end

endmodule

// ==== hex_text_map.sv ====
/* Hex text cell mapping */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module hex_text_map (
    input logic clock_50,
    input logic rst,
    lcd_scan_if.sink scan_in,
    lcd_scan_if.source scan_out,
    input logic [31:0] debug0,
    input logic [31:0] debug1,
    input logic [31:0] debug2,
    output logic [3:0] digit,
    output logic digit_valid,
    output logic [2:0] glyph_col,
    output logic [3:0] glyph_row
);

    // Screen pixels per cell, as shifts. 32 across, 64 down.
    localparam int COL_SHIFT = `TEXT_LOG2_SCALE + $clog2(`GLYPH_W);
    localparam int ROW_SHIFT = `TEXT_LOG2_SCALE + $clog2(`GLYPH_H);

    logic [`LCD_X_BITS-COL_SHIFT-1:0] text_col;
    logic [`LCD_Y_BITS-ROW_SHIFT-1:0] text_row;
    logic [31:0] row_word;
    logic [2:0] nibble;
    logic [3:0] cell_digit;
    logic cell_valid;

    // Cell index and position inside the cell.
    assign text_col = scan_in.x[`LCD_X_BITS-1:COL_SHIFT];
    assign text_row = scan_in.y[`LCD_Y_BITS-1:ROW_SHIFT];

    // One debug word per text row.
    always_comb begin
        case (text_row)
            'd0: row_word = debug0;
            'd1: row_word = debug1;
            default: row_word = debug2;
        endcase
    end

    // Column 0 shows the top nibble.
    assign nibble = 3'(`TEXT_DIGITS - 1) - text_col[2:0];
    assign cell_digit = row_word[{nibble, 2'b00} +: 4];
    assign cell_valid = (text_row < `TEXT_WORDS) && (text_col < `TEXT_DIGITS);

    // Pixel tick passes straight on.
    assign scan_out.tick = scan_in.tick;

    // Sync state of the delayed scan.
    always_ff @(posedge clock_50) begin
        if (rst) begin
            scan_out.de <= 1'b0;
            scan_out.hs_n <= 1'b1;
            scan_out.vs_n <= 1'b1;
            digit_valid <= 1'b0;
        end else if (scan_in.tick) begin
            scan_out.de <= scan_in.de;
            scan_out.hs_n <= scan_in.hs_n;
            scan_out.vs_n <= scan_in.vs_n;
            digit_valid <= cell_valid;
        end
    end

    // Cell payload, one tick behind like the sync.
    always_ff @(posedge clock_50) begin
        if (scan_in.tick) begin
            scan_out.x <= scan_in.x;
            scan_out.y <= scan_in.y;
            digit <= cell_digit;
            glyph_col <= scan_in.x[`TEXT_LOG2_SCALE +: 3];
            glyph_row <= scan_in.y[`TEXT_LOG2_SCALE +: 4];
        end
    end

endmodule

// ==== seg_glyph.sv ====
/* Seven segment glyph renderer */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module seg_glyph (
    input logic clock_50,
    input logic rst,
    lcd_scan_if.sink scan,
    input logic [3:0] digit,
    input logic digit_valid,
    input logic [2:0] glyph_col,
    input logic [3:0] glyph_row,
    input logic overlay_en,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic de,
    output logic hs_n,
    output logic vs_n
);

    // Segment order a b c d e f g, a in the top bit.
    logic [6:0] segs;
    logic [6:0] seg_here;
    logic mid_col;
    logic upper_row;
    logic lower_row;
    logic lit;

    // Hex segment sets.
    always_comb begin
        case (digit)
            4'h0: segs = 7'b1111110;
            4'h1: segs = 7'b0110000;
            4'h2: segs = 7'b1101101;
            4'h3: segs = 7'b1111001;
            4'h4: segs = 7'b0110011;
            4'h5: segs = 7'b1011011;
            4'h6: segs = 7'b1011111;
            4'h7: segs = 7'b1110000;
            4'h8: segs = 7'b1111111;
            4'h9: segs = 7'b1111011;
            4'ha: segs = 7'b1110111;
            4'hb: segs = 7'b0011111;
            4'hc: segs = 7'b1001110;
            4'hd: segs = 7'b0111101;
            4'he: segs = 7'b1001111;
            default: segs = 7'b1000111;
        endcase
    end

    // Which segments cover this cell pixel.
    assign mid_col = (glyph_col >= 3'd1) && (glyph_col <= 3'd6);
    assign upper_row = (glyph_row >= 4'd1) && (glyph_row <= 4'd7);
    assign lower_row = (glyph_row >= 4'd8) && (glyph_row <= 4'd14);
    assign seg_here = {
        (glyph_row == 4'd1) && mid_col,
        (glyph_col == 3'd6) && upper_row,
        (glyph_col == 3'd6) && lower_row,
        (glyph_row == 4'd14) && mid_col,
        (glyph_col == 3'd1) && lower_row,
        (glyph_col == 3'd1) && upper_row,
        (glyph_row == 4'd7) && mid_col
    };
    assign lit = |(segs & seg_here);

    // Red text on black.
    assign green = 8'h00;
    assign blue = 8'h00;

    // Output stage.
    always_ff @(posedge clock_50) begin
        if (rst) begin
            red <= 8'h00;
            de <= 1'b0;
            hs_n <= 1'b1;
            vs_n <= 1'b1;
        end else if (scan.tick) begin
            red <= (lit && scan.de && digit_valid && overlay_en) ? `OVERLAY_RED : 8'h00;
            de <= scan.de;
            hs_n <= scan.hs_n;
            vs_n <= scan.vs_n;
        end
    end

endmodule

// ==== backlight_pwm.sv ====
/* Backlight PWM */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module backlight_pwm import lcd_pkg::*; (
    input logic clock_50,
    input logic rst,
    input host_word_u ctrl,
    output logic pwm
);

    localparam int PRE_BITS = $clog2(`PWM_PRESCALE);
    localparam logic [PRE_BITS-1:0] PRE_LAST = `PWM_PRESCALE - 1;
    localparam logic [`PWM_BITS-1:0] PHASE_LAST = `PWM_MAX - 1;
    localparam logic [`PWM_BITS-1:0] LEVEL_FULL = `PWM_MAX;

    logic [PRE_BITS-1:0] pre_cnt;
    logic [`PWM_BITS-1:0] phase;
    logic [`PWM_BITS-1:0] level;

    // Host level, or full until the host selects one.
    always_comb begin
        if (!ctrl.ctrl.brightness_sel) begin
            level = LEVEL_FULL;
        end else if (ctrl.ctrl.brightness > LEVEL_FULL) begin
            // Clamp.
            level = LEVEL_FULL;
        end else begin
            level = ctrl.ctrl.brightness;
        end
    end

    // Phase steps every PWM_PRESCALE clocks.
    always_ff @(posedge clock_50) begin
        if (rst) begin
            pre_cnt <= '0;
            phase <= '0;
            pwm <= 1'b0;
        end else begin
            pre_cnt <= (pre_cnt == PRE_LAST) ? '0 : pre_cnt + 1'b1;
            if (pre_cnt == PRE_LAST) begin
                phase <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;
            end
            // High for the first level phases.
            pwm <= phase < level;
        end
    end

endmodule

// ==== host_regs.sv ====
/* AXI4-Lite host registers */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module host_regs import lcd_pkg::*; (
    input logic clock_50,
    input logic rst,
    input logic [31:0] awaddr,
    input logic awvalid,
    output logic awready,
    input logic [31:0] wdata,
    input logic [3:0] wstrb,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [31:0] araddr,
    input logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready,
    output logic [31:0] debug0,
    output logic [31:0] debug1,
    output logic [31:0] debug2,
    output host_word_u ctrl
);

    logic wr_accept;
    logic wr_hit;
    logic rd_hit;
    logic [31:0] rd_word;

    // Byte lanes of data replace those of old.
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Address and data are taken together.
    assign awready = wr_accept;
    assign wready = wr_accept;
    // One read outstanding at a time.
    assign arready = !rvalid;

    // Write decode.
    always_comb begin
        case (awaddr)
            `REG_DEBUG0, `REG_DEBUG1, `REG_DEBUG2, `REG_CTRL: wr_hit = 1'b1;
            default: wr_hit = 1'b0;
        endcase
    end

    // Read decode and mux.
    always_comb begin
        rd_hit = 1'b1;
        case (araddr)
            `REG_DEBUG0: rd_word = debug0;
            `REG_DEBUG1: rd_word = debug1;
            `REG_DEBUG2: rd_word = debug2;
            `REG_CTRL: rd_word = ctrl.raw;
            default: begin
                rd_word = 32'h0;
                rd_hit = 1'b0;
            end
        endcase
    end

    // Handshakes and register storage.
    always_ff @(posedge clock_50) begin
        if (rst) begin
            wr_accept <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            debug0 <= `DEBUG0_RESET;
            debug1 <= `DEBUG1_RESET;
            debug2 <= `DEBUG2_RESET;
            // Text on, backlight at full.
            ctrl.raw <= 32'h0000_0001;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_accept) begin
                // Ready lasts a single cycle.
                wr_accept <= 1'b0;
                bvalid <= 1'b1;
                case (awaddr)
                    `REG_DEBUG0: debug0 <= merge_bytes(debug0, wdata, wstrb);
                    `REG_DEBUG1: debug1 <= merge_bytes(debug1, wdata, wstrb);
                    `REG_DEBUG2: debug2 <= merge_bytes(debug2, wdata, wstrb);
                    `REG_CTRL: ctrl.raw <= merge_bytes(ctrl.raw, wdata, wstrb);
                    default: ;
                endcase
            end else if (awvalid && wvalid && !bvalid) begin
                wr_accept <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Response payload.
    always_ff @(posedge clock_50) begin
        if (wr_accept) begin
            bresp <= wr_hit ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
        end
        if (arvalid && arready) begin
            rresp <= rd_hit ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
            rdata <= rd_word;
        end
    end

endmodule

// ==== lcd_debug_top.sv ====
/* LCD debug display top */

`timescale 1ns/1ps

module lcd_debug_top import lcd_pkg::*; (
    input logic clock_50,
    input logic rst,
    // AXI4-Lite host port.
    input logic [31:0] awaddr,
    input logic awvalid,
    output logic awready,
    input logic [31:0] wdata,
    input logic [3:0] wstrb,
    input logic wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input logic bready,
    input logic [31:0] araddr,
    input logic arvalid,
    output logic arready,
    output logic [31:0] rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input logic rready,
    // Panel.
    output logic lcd_clk,
    output logic [7:0] lcd_red,
    output logic [7:0] lcd_green,
    output logic [7:0] lcd_blue,
    output logic lcd_de,
    output logic lcd_hs_n,
    output logic lcd_vs_n,
    output logic lcd_pwm
);

    logic [31:0] debug0;
    logic [31:0] debug1;
    logic [31:0] debug2;
    host_word_u ctrl;
    logic [3:0] digit;
    logic digit_valid;
    logic [2:0] glyph_col;
    logic [3:0] glyph_row;

    // Raw scan, then the scan one tick later.
    lcd_scan_if scan_raw ();
    lcd_scan_if scan_cell ();

    // The tick doubles as the panel clock.
    assign lcd_clk = scan_raw.tick;

    lcd_timing u_timing (.clock_50(clock_50), .rst(rst), .scan(scan_raw));

    hex_text_map u_text (
        .clock_50(clock_50), .rst(rst),
        .scan_in(scan_raw), .scan_out(scan_cell),
        .debug0(debug0), .debug1(debug1), .debug2(debug2),
        .digit(digit), .digit_valid(digit_valid),
        .glyph_col(glyph_col), .glyph_row(glyph_row)
    );

    seg_glyph u_glyph (
        .clock_50(clock_50), .rst(rst), .scan(scan_cell),
        .digit(digit), .digit_valid(digit_valid),
        .glyph_col(glyph_col), .glyph_row(glyph_row),
        .overlay_en(ctrl.ctrl.overlay_en),
        .red(lcd_red), .green(lcd_green), .blue(lcd_blue),
        .de(lcd_de), .hs_n(lcd_hs_n), .vs_n(lcd_vs_n)
    );

    backlight_pwm u_pwm (.clock_50(clock_50), .rst(rst), .ctrl(ctrl), .pwm(lcd_pwm));

    host_regs u_regs (
        .clock_50(clock_50), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .debug0(debug0), .debug1(debug1), .debug2(debug2), .ctrl(ctrl)
    );

endmodule

// ==== tb_lcd_debug.sv ====
/* LCD debug display testbench */

`timescale 1ns/1ps

`include "lcd_cfg.svh"

module tb_lcd_debug;

    // Clock edges allowed per handshake.
    localparam int WAIT_LIMIT = 64;
    // Pixel ticks allowed per frame search.
    localparam int FRAME_LIMIT = 600000;
    // Screen pixels per text cell.
    localparam int CELL_W = `GLYPH_W << `TEXT_LOG2_SCALE;
    localparam int CELL_H = `GLYPH_H << `TEXT_LOG2_SCALE;
    localparam int SCALE = 1 << `TEXT_LOG2_SCALE;

    logic clock_50;
    logic rst;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic lcd_clk;
    logic [7:0] lcd_red;
    logic [7:0] lcd_green;
    logic [7:0] lcd_blue;
    logic lcd_de;
    logic lcd_hs_n;
    logic lcd_vs_n;
    logic lcd_pwm;

    int errors;
    int checks;
    logic [15:0] lfsr_state;
    // Debug words as written, and the control word.
    logic [31:0] words [3];
    logic [31:0] ctrl_exp;
    logic [1:0] resp;
    logic [31:0] rd;
    // One pixel as seen on the panel pins.
    logic s_de;
    logic s_hs_n;
    logic s_vs_n;
    logic [23:0] s_rgb;

    lcd_debug_top u_dut (.*);

    initial begin
        clock_50 = 1'b0;
        forever #20 clock_50 = ~clock_50;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("Checks %0d, errors %0d", checks, errors + 1);
        $display("TEST FAIL");
        $finish;
    endtask

    // Taps 16, 14, 13, 11.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    function automatic logic [31:0] ctrl_word(input int level, input logic sel,
                                              input logic overlay);
        return {20'h0, 10'(level), sel, overlay};
    endfunction

    // Segment set with a in bit 0 and g in bit 6.
    function automatic logic [6:0] hex_segments(input logic [3:0] d);
        case (d)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // Red level at visible pixel px, py.
    function automatic logic [7:0] expected_red(input int px, input int py);
        int col;
        int row;
        int gc;
        int gr;
        logic [6:0] s;
        logic mid;
        logic up;
        logic low;
        logic on;
        col = px / CELL_W;
        row = py / CELL_H;
        if (row >= 3 || col >= `TEXT_DIGITS) return 8'h00;
        s = hex_segments(4'(words[row] >> (4 * (`TEXT_DIGITS - 1 - col))));
        gc = (px / SCALE) % `GLYPH_W;
        gr = (py / SCALE) % `GLYPH_H;
        mid = (gc >= 1) && (gc <= 6);
        up = (gr >= 1) && (gr <= 7);
        low = (gr >= 8) && (gr <= 14);
        on = (s[0] && gr == 1 && mid) || (s[1] && gc == 6 && up)
            || (s[2] && gc == 6 && low) || (s[3] && gr == 14 && mid)
            || (s[4] && gc == 1 && low) || (s[5] && gc == 1 && up)
            || (s[6] && gr == 7 && mid);
        return on ? `OVERLAY_RED : 8'h00;
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] value,
                             output logic [1:0] resp_got);
        int n;
        @(posedge clock_50);
        awaddr <= addr;
        wdata <= value;
        wstrb <= 4'hf;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        n = 0;
        do begin
            @(posedge clock_50);
            n++;
        end while (!(awready && wready) && n < WAIT_LIMIT);
        if (!(awready && wready)) abort_run("write address and data never accepted");
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clock_50);
            n++;
        end while (!bvalid && n < WAIT_LIMIT);
        if (!bvalid) abort_run("no write response");
        resp_got = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data_got,
                            output logic [1:0] resp_got);
        int n;
        @(posedge clock_50);
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= 1'b1;
        n = 0;
        do begin
            @(posedge clock_50);
            n++;
        end while (!arready && n < WAIT_LIMIT);
        if (!arready) abort_run("read address never accepted");
        arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge clock_50);
            n++;
        end while (!rvalid && n < WAIT_LIMIT);
        if (!rvalid) abort_run("no read response");
        data_got = rdata;
        resp_got = rresp;
        rready <= 1'b0;
    endtask

    task automatic read_all_regs();
        for (int k = 0; k < 3; k++) begin
            axi_read(`REG_DEBUG0 + 4 * k, rd, resp);
            check_value($sformatf("debug%0d readback", k), rd, words[k]);
            check_value("debug rresp", resp, `AXI_RESP_OKAY);
        end
        axi_read(`REG_CTRL, rd, resp);
        check_value("ctrl readback", rd, ctrl_exp);
        check_value("ctrl rresp", resp, `AXI_RESP_OKAY);
    endtask

    task automatic check_reset_state(input string tag);
        check_value({tag, " de"}, lcd_de, 1'b0);
        check_value({tag, " hs_n"}, lcd_hs_n, 1'b1);
        check_value({tag, " vs_n"}, lcd_vs_n, 1'b1);
        check_value({tag, " rgb"}, {lcd_red, lcd_green, lcd_blue}, 24'h0);
        check_value({tag, " pwm"}, lcd_pwm, 1'b0);
        check_value({tag, " bvalid"}, bvalid, 1'b0);
        check_value({tag, " rvalid"}, rvalid, 1'b0);
        check_value({tag, " awready"}, awready, 1'b0);
        check_value({tag, " wready"}, wready, 1'b0);
        check_value({tag, " arready"}, arready, 1'b1);
    endtask

    // Samples the pins on the clock edge that ends a pixel.
    task automatic wait_pixel();
        int n;
        logic got;
        n = 0;
        do begin
            @(posedge clock_50);
            n++;
            got = lcd_clk;
        end while (!got && n < WAIT_LIMIT);
        if (!got) abort_run("pixel tick stopped");
        s_de = lcd_de;
        s_hs_n = lcd_hs_n;
        s_vs_n = lcd_vs_n;
        s_rgb = {lcd_red, lcd_green, lcd_blue};
    endtask

    task automatic scan_frame(input logic overlay_on);
        int n;
        int de_x;
        int de_y;
        int last_rise;
        int hs_run;
        int hs_runs;
        int vs_low;
        logic prev_de;
        logic prev_hs;
        logic [23:0] exp_rgb;
        n = 0;
        do begin
            wait_pixel();
            n++;
        end while (s_vs_n && n < FRAME_LIMIT);
        if (s_vs_n) abort_run("no vertical sync");
        n = 0;
        do begin
            wait_pixel();
            n++;
        end while (!s_de && n < FRAME_LIMIT);
        if (!s_de) abort_run("no active video after vertical sync");
        // Now at the first visible pixel of a frame.
        de_x = 0;
        de_y = 0;
        last_rise = -1;
        hs_run = 0;
        hs_runs = 0;
        vs_low = 0;
        prev_de = 1'b0;
        prev_hs = 1'b1;
        for (int i = 0; i < `LCD_H_TOTAL * `LCD_V_TOTAL; i++) begin
            if (i > 0) wait_pixel();
            if (s_de && !prev_de) begin
                if (last_rise >= 0) check_value("line period", i - last_rise, `LCD_H_TOTAL);
                last_rise = i;
            end
            if (!s_de && prev_de) begin
                check_value("de ticks per line", de_x, `LCD_H_ACTIVE);
                de_x = 0;
                de_y++;
            end
            if (!s_hs_n) hs_run++;
            if (s_hs_n && !prev_hs) begin
                check_value("hs_n low ticks", hs_run, `LCD_H_SYNC);
                hs_run = 0;
                hs_runs++;
            end
            if (!s_vs_n) vs_low++;
            exp_rgb = 24'h0;
            if (s_de && overlay_on) exp_rgb = {expected_red(de_x, de_y), 16'h0};
            checks++;
            assert (s_rgb === exp_rgb) else begin
                errors++;
                $display("FAILED at %0t: pixel %0d,%0d rgb %h expected %h",
                         $time, de_x, de_y, s_rgb, exp_rgb);
            end
            if (s_de) de_x++;
            prev_de = s_de;
            prev_hs = s_hs_n;
        end
        check_value("de lines per frame", de_y, `LCD_V_ACTIVE);
        check_value("hs pulses per frame", hs_runs, `LCD_V_TOTAL);
        check_value("vs_n low ticks", vs_low, `LCD_V_SYNC * `LCD_H_TOTAL);
    endtask

    // Counts pwm high clocks over one full PWM period.
    task automatic measure_pwm(input int exp_high, input string what);
        int high;
        high = 0;
        repeat (4) @(posedge clock_50);
        repeat (`PWM_PRESCALE * `PWM_MAX) begin
            @(posedge clock_50);
            if (lcd_pwm) high++;
        end
        check_value(what, high, exp_high);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        lfsr_state = 16'd29352;
        rst = 1'b1;
        awaddr = 32'h0;
        awvalid = 1'b0;
        wdata = 32'h0;
        wstrb = 4'h0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = 32'h0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (3) @(posedge clock_50);
        check_reset_state("in reset");
        @(posedge clock_50);
        rst <= 1'b0;
        @(posedge clock_50);
        check_reset_state("after reset");

        // Register write and readback.
        for (int k = 0; k < 3; k++) begin
            words[k] = rand_word();
            axi_write(`REG_DEBUG0 + 4 * k, words[k], resp);
            check_value("debug bresp", resp, `AXI_RESP_OKAY);
        end
        // Level stored but not selected.
        ctrl_exp = ctrl_word(512, 1'b0, 1'b1);
        axi_write(`REG_CTRL, ctrl_exp, resp);
        check_value("ctrl bresp", resp, `AXI_RESP_OKAY);
        read_all_regs();

        // Unmapped address.
        axi_write(32'h10, 32'h1234_5678, resp);
        check_value("unmapped bresp", resp, `AXI_RESP_SLVERR);
        axi_read(32'h10, rd, resp);
        check_value("unmapped rresp", resp, `AXI_RESP_SLVERR);
        check_value("unmapped rdata", rd, 32'h0);
        read_all_regs();

        // Frame timing and text, then overlay off.
        scan_frame(1'b1);
        ctrl_exp = ctrl_word(0, 1'b0, 1'b0);
        axi_write(`REG_CTRL, ctrl_exp, resp);
        scan_frame(1'b0);

        // Backlight levels.
        measure_pwm(`PWM_PRESCALE * `PWM_MAX, "pwm high clocks at full");
        axi_write(`REG_CTRL, ctrl_word(300, 1'b1, 1'b0), resp);
        measure_pwm(`PWM_PRESCALE * 300, "pwm high clocks at 300");
        axi_write(`REG_CTRL, ctrl_word(0, 1'b1, 1'b0), resp);
        measure_pwm(0, "pwm high clocks at 0");

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
lcd_pkg.sv
lcd_scan_if.sv
lcd_timing.sv
hex_text_map.sv
seg_glyph.sv
backlight_pwm.sv
host_regs.sv
lcd_debug_top.sv
tb_lcd_debug.sv
